/* rtl/avionics_pkg.sv */
//----------------------------------------------------------------------
// Avionics debug telemetry package
// Shared timing constants, message encoding and handshake structs
//----------------------------------------------------------------------

package avionics_pkg;

  // Elapsed-time and decimal widths
  localparam int TIME_BITS  = 24;
  localparam int BCD_DIGITS = 8;

  // Board timing, 50 MHz clock
  localparam int CLKS_PER_MS  = 50000;
  // 115200 baud
  localparam int CLKS_PER_BIT = 434;

  // Report cadence and message length
  localparam int REPORT_MS = 100;
  // Eight digits plus CR LF
  localparam int MSG_BYTES = 10;

  // ASCII encoding of the message
  localparam logic [7:0] ASCII_ZERO = 8'h30;
  localparam logic [7:0] ASCII_CR   = 8'h0D;
  localparam logic [7:0] ASCII_LF   = 8'h0A;

  // Elapsed milliseconds since reset
  typedef logic [TIME_BITS-1:0] timestamp_t;

  // Packed BCD, most significant digit in the top nibble
  typedef logic [4*BCD_DIGITS-1:0] bcd_t;

  // Converter request, operand held while req is high
  typedef struct packed {
    logic       req;
    timestamp_t operand;
  } conv_req_t;

  // Converter response, result valid while ack is high
  typedef struct packed {
    logic ack;
    bcd_t result;
  } conv_rsp_t;

  // One byte for the serial transmitter
  typedef struct packed {
    logic       req;
    logic [7:0] data;
  } tx_req_t;

endpackage

/* rtl/ms_clock.sv */
//----------------------------------------------------------------------
// Millisecond time base
// Counts elapsed milliseconds and flags every report interval
//----------------------------------------------------------------------

`timescale 1ns/1ps

module ms_clock #(
  parameter int CLKS_PER_MS = avionics_pkg::CLKS_PER_MS
) (
  input  logic                     clk,
  input  logic                     reset,
  output avionics_pkg::timestamp_t ms_time,
  output logic                     report_tick
);

  localparam int DIV_W = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;
  localparam int REP_W = $clog2(avionics_pkg::REPORT_MS);

  // Clock cycles within the current millisecond
  logic [DIV_W-1:0] div_cnt;
  // Milliseconds within the current report interval
  logic [REP_W-1:0] rep_cnt;
  // Last cycle of a millisecond
  logic             ms_tick;

  assign ms_tick = (div_cnt == DIV_W'(CLKS_PER_MS - 1));

  // Cycle divider
  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (ms_tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Elapsed count and report interval
  // report_tick is high in the cycle where the new count is visible
  always_ff @(posedge clk) begin
    if (reset) begin
      ms_time     <= '0;
      rep_cnt     <= '0;
      report_tick <= 1'b0;
    end else begin
      report_tick <= 1'b0;
      if (ms_tick) begin
        ms_time <= ms_time + 1'b1;
        // Wrap means the new count is a multiple of REPORT_MS
        if (rep_cnt == REP_W'(avionics_pkg::REPORT_MS - 1)) begin
          rep_cnt     <= '0;
          report_tick <= 1'b1;
        end else begin
          rep_cnt <= rep_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* rtl/bin_to_bcd.sv */
//----------------------------------------------------------------------
// Binary to packed BCD converter
// Iterative double dabble, one bit per cycle, four-phase handshake
//----------------------------------------------------------------------

`timescale 1ns/1ps

module bin_to_bcd (
  input  logic                    clk,
  input  logic                    reset,
  input  avionics_pkg::conv_req_t conv_req,
  output avionics_pkg::conv_rsp_t conv_rsp
);

  localparam int STEP_W = $clog2(avionics_pkg::TIME_BITS);
  localparam int BCD_W  = $bits(avionics_pkg::bcd_t);

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    DONE
  } state_t;

  state_t                   state;
  logic [STEP_W-1:0]        step_cnt;
  // Operand bits still to shift in
  avionics_pkg::timestamp_t bin_sr;
  // Partial decimal result
  avionics_pkg::bcd_t       bcd_sr;
  avionics_pkg::bcd_t       bcd_adj;

  // Add three to every digit of five or more
  function automatic avionics_pkg::bcd_t add_three(input avionics_pkg::bcd_t value);
    avionics_pkg::bcd_t adj;
    adj = value;
    for (int i = 0; i < avionics_pkg::BCD_DIGITS; i++) begin
      if (value[4*i +: 4] >= 4'd5) begin
        adj[4*i +: 4] = value[4*i +: 4] + 4'd3;
      end
    end
    return adj;
  endfunction

  assign bcd_adj = add_three(bcd_sr);

  // Handshake and step control
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          // ack is low here, so a high req is a fresh request
          if (conv_req.req) begin
            state    <= SHIFT;
            step_cnt <= '0;
          end
        end
        SHIFT: begin
          if (step_cnt == STEP_W'(avionics_pkg::TIME_BITS - 1)) begin
            state <= DONE;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        DONE: begin
          // Hold result until requester lets go
          if (!conv_req.req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift registers
  always_ff @(posedge clk) begin
    if (state == IDLE && conv_req.req) begin
      bin_sr <= conv_req.operand;
      bcd_sr <= '0;
    end else if (state == SHIFT) begin
      // Adjust then shift in the next operand bit, MSB first
      bcd_sr <= {bcd_adj[BCD_W-2:0], bin_sr[avionics_pkg::TIME_BITS-1]};
      bin_sr <= bin_sr << 1;
    end
  end

  assign conv_rsp = '{ack: (state == DONE), result: bcd_sr};

endmodule

/* rtl/uart_tx.sv */
//----------------------------------------------------------------------
// UART transmitter, 8N1
// One byte per four-phase request, held off while the host is busy
//----------------------------------------------------------------------

`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = avionics_pkg::CLKS_PER_BIT
) (
  input  logic                  clk,
  input  logic                  reset,
  input  avionics_pkg::tx_req_t tx_req,
  input  logic                  tx_block,
  output logic                  tx_ack,
  output logic                  tx
);

  localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    STOP,
    ACK
  } state_t;

  state_t            state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [2:0]        bit_idx;
  // Byte being sent, LSB goes out next
  logic [7:0]        data_sr;
  logic              bit_done;
  logic              start_byte;

  // End of the current bit period
  assign bit_done   = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
  // New byte only when the host is ready
  assign start_byte = (state == IDLE) && tx_req.req && !tx_block;

  // Framing FSM and line driver
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end else begin
      // Bit timer runs only while framing
      if (state inside {START, DATA, STOP} && !bit_done) begin
        baud_cnt <= baud_cnt + 1'b1;
      end else begin
        baud_cnt <= '0;
      end
      case (state)
        IDLE: begin
          if (start_byte) begin
            state <= START;
            tx    <= 1'b0;
          end
        end
        START: begin
          if (bit_done) begin
            state   <= DATA;
            bit_idx <= '0;
            tx      <= data_sr[0];
          end
        end
        DATA: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              state <= STOP;
              tx    <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              // Register shifts on this edge, so bit 1 is next
              tx      <= data_sr[1];
            end
          end
        end
        STOP: begin
          if (bit_done) begin
            state <= ACK;
          end
        end
        ACK: begin
          if (!tx_req.req) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data shift register
  always_ff @(posedge clk) begin
    if (start_byte) begin
      data_sr <= tx_req.data;
    end else if (state == DATA && bit_done) begin
      data_sr <= data_sr >> 1;
    end
  end

  // Stop bit done, held until req falls
  assign tx_ack = (state == ACK);

endmodule

/* rtl/debug_ctrl.sv */
//----------------------------------------------------------------------
// Debug report control
// Samples the time, has it converted, sends it as ASCII decimal
// followed by CR LF and counts the messages sent
//----------------------------------------------------------------------

`timescale 1ns/1ps

module debug_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  avionics_pkg::timestamp_t ms_time,
  input  logic                     report_tick,
  output avionics_pkg::conv_req_t  conv_req,
  input  avionics_pkg::conv_rsp_t  conv_rsp,
  output avionics_pkg::tx_req_t    tx_req,
  input  logic                     tx_ack,
  output logic [7:0]               led
);

  localparam int IDX_W = $clog2(avionics_pkg::MSG_BYTES);

  typedef enum logic [2:0] {
    IDLE,
    CONVERT,
    SEND_BYTE,
    WAIT_ACK_LOW,
    NEXT
  } state_t;

  state_t                   state;
  // Sampled time, operand for the converter
  avionics_pkg::timestamp_t time_q;
  // Decimal digits of the current message
  avionics_pkg::bcd_t       bcd_q;
  logic                     conv_req_q;
  logic                     tx_req_q;
  // Position within the message
  logic [IDX_W-1:0]         byte_idx;
  logic [7:0]               msg_cnt;
  logic [7:0]               cur_byte;

  // Message byte at a given position
  // Digits first, MSD at position 0, then CR and LF
  function automatic logic [7:0] msg_byte(input avionics_pkg::bcd_t bcd,
                                          input logic [IDX_W-1:0] idx);
    logic [3:0] digit;
    int         pos;
    digit = 4'h0;
    pos   = avionics_pkg::BCD_DIGITS - 1 - int'(idx);
    if (int'(idx) < avionics_pkg::BCD_DIGITS) begin
      digit    = bcd[4*pos +: 4];
      msg_byte = avionics_pkg::ASCII_ZERO + {4'h0, digit};
    end else if (int'(idx) == avionics_pkg::BCD_DIGITS) begin
      msg_byte = avionics_pkg::ASCII_CR;
    end else begin
      msg_byte = avionics_pkg::ASCII_LF;
    end
  endfunction

  // Stable while tx req is high, index moves only in NEXT
  assign cur_byte = msg_byte(bcd_q, byte_idx);

  // Sequencer
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      conv_req_q <= 1'b0;
      tx_req_q   <= 1'b0;
      byte_idx   <= '0;
      msg_cnt    <= '0;
    end else begin
      case (state)
        IDLE: begin
          // Ticks outside IDLE are dropped
          if (report_tick) begin
            conv_req_q <= 1'b1;
            state      <= CONVERT;
          end
        end
        CONVERT: begin
          if (conv_rsp.ack) begin
            conv_req_q <= 1'b0;
            tx_req_q   <= 1'b1;
            byte_idx   <= '0;
            state      <= SEND_BYTE;
          end
        end
        SEND_BYTE: begin
          // Byte is on the line once ack shows up
          if (tx_ack) begin
            tx_req_q <= 1'b0;
            state    <= WAIT_ACK_LOW;
          end
        end
        WAIT_ACK_LOW: begin
          if (!tx_ack) begin
            state <= NEXT;
          end
        end
        NEXT: begin
          if (byte_idx == IDX_W'(avionics_pkg::MSG_BYTES - 1)) begin
            // Message complete
            msg_cnt <= msg_cnt + 1'b1;
            state   <= IDLE;
          end else begin
            byte_idx <= byte_idx + 1'b1;
            tx_req_q <= 1'b1;
            state    <= SEND_BYTE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Time sample and conversion result
  always_ff @(posedge clk) begin
    if (state == IDLE && report_tick) begin
      time_q <= ms_time;
    end
    if (state == CONVERT && conv_rsp.ack) begin
      bcd_q <= conv_rsp.result;
    end
  end

  assign conv_req = '{req: conv_req_q, operand: time_q};
  assign tx_req   = '{req: tx_req_q, data: cur_byte};

  // Message count, wraps at 256
  assign led = msg_cnt;

endmodule

/* rtl/avionics.sv */
//----------------------------------------------------------------------
// Avionics board debug telemetry top level
// Time base, BCD converter, UART transmitter and report control
//----------------------------------------------------------------------

`timescale 1ns/1ps

module avionics #(
  parameter int CLKS_PER_MS  = avionics_pkg::CLKS_PER_MS,
  parameter int CLKS_PER_BIT = avionics_pkg::CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       reset,
  // Host hold-off, high while the host cannot take data
  input  logic       tx_block,
  output logic       tx,
  // Messages sent, low byte
  output logic [7:0] led
);

  // Time base to control
  avionics_pkg::timestamp_t ms_time;
  logic                     report_tick;

  // Control to converter and back
  avionics_pkg::conv_req_t conv_req;
  avionics_pkg::conv_rsp_t conv_rsp;

  // Control to transmitter and back
  avionics_pkg::tx_req_t tx_req;
  logic                  tx_ack;

  // Millisecond time base
  ms_clock #(
    .CLKS_PER_MS(CLKS_PER_MS)
  ) ms_clock_i (
    .clk        (clk),
    .reset      (reset),
    .ms_time    (ms_time),
    .report_tick(report_tick)
  );

  // Report sequencing
  debug_ctrl debug_ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .ms_time    (ms_time),
    .report_tick(report_tick),
    .conv_req   (conv_req),
    .conv_rsp   (conv_rsp),
    .tx_req     (tx_req),
    .tx_ack     (tx_ack),
    .led        (led)
  );

  // Binary to packed BCD
  bin_to_bcd bin_to_bcd_i (
    .clk     (clk),
    .reset   (reset),
    .conv_req(conv_req),
    .conv_rsp(conv_rsp)
  );

  // Serial line to the host
  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_tx_i (
    .clk     (clk),
    .reset   (reset),
    .tx_req  (tx_req),
    .tx_block(tx_block),
    .tx_ack  (tx_ack),
    .tx      (tx)
  );

endmodule

/* tests/avionics_chk.sv */
//----------------------------------------------------------------------
// Avionics handshake checker
// Concurrent assertions on both four-phase links and the idle line
//----------------------------------------------------------------------

`timescale 1ns/1ps

module avionics_chk (
  input logic                    clk,
  input logic                    reset,
  input avionics_pkg::conv_req_t conv_req,
  input avionics_pkg::conv_rsp_t conv_rsp,
  input avionics_pkg::tx_req_t   tx_req,
  input logic                    tx_ack,
  input logic                    tx,
  // Transmitter FSM state, zero is idle
  input logic [2:0]              uart_state
);

  // Every packed digit must be 0 to 9
  function automatic bit digits_ok(input avionics_pkg::bcd_t value);
    bit ok;
    ok = 1'b1;
    for (int i = 0; i < avionics_pkg::BCD_DIGITS; i++) begin
      if (value[4*i +: 4] > 4'd9) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // Req falls only after ack was seen
  conv_req_held: assert property (@(posedge clk) disable iff (reset)
    $fell(conv_req.req) |-> $past(conv_rsp.ack))
    else $error("conv req dropped before ack");

  tx_req_held: assert property (@(posedge clk) disable iff (reset)
    $fell(tx_req.req) |-> $past(tx_ack))
    else $error("tx req dropped before ack");

  // Ack rises only under a live req
  conv_ack_has_req: assert property (@(posedge clk) disable iff (reset)
    $rose(conv_rsp.ack) |-> conv_req.req)
    else $error("conv ack raised without req");

  tx_ack_has_req: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_ack) |-> tx_req.req)
    else $error("tx ack raised without req");

  conv_digits_valid: assert property (@(posedge clk) disable iff (reset)
    conv_rsp.ack |-> digits_ok(conv_rsp.result))
    else $error("BCD digit above 9 while conv ack is high");

  // Line rests high between bytes
  tx_idle_high: assert property (@(posedge clk) disable iff (reset)
    (uart_state == 3'd0) |-> tx)
    else $error("tx low while transmitter idle");

endmodule

bind avionics avionics_chk avionics_chk_i (
  .clk       (clk),
  .reset     (reset),
  .conv_req  (conv_req),
  .conv_rsp  (conv_rsp),
  .tx_req    (tx_req),
  .tx_ack    (tx_ack),
  .tx        (tx),
  .uart_state(uart_tx_i.state)
);

/* tests/avionics_tb.sv */
//----------------------------------------------------------------------
// Avionics debug telemetry testbench
// Decodes the serial messages and checks them against the report rules
//----------------------------------------------------------------------

`timescale 1ns/1ps

module avionics_tb;

  localparam int CLKS_MS    = 40;
  localparam int CLKS_BIT   = 8;
  localparam int NB         = avionics_pkg::MSG_BYTES;
  localparam int REPORT_CYC = CLKS_MS * avionics_pkg::REPORT_MS;
  // Leaves room for a skipped report
  localparam int START_TIMEOUT = 3 * REPORT_CYC;
  localparam int LED_TIMEOUT   = 64;

  // Byte 0 in the top byte
  typedef logic [8*NB-1:0] msg_t;

  logic        clk;
  logic        reset;
  logic        tx_block;
  logic        tx;
  logic [7:0]  led;

  logic [31:0] lfsr_state;
  bit          random_holdoff;
  bit          timed_out;
  int          errors;
  int          checks;
  int          tests_ok;
  int          tests_bad;
  int          errors_at_start;
  int          msgs_seen;
  int unsigned last_value;

  avionics #(
    .CLKS_PER_MS (CLKS_MS),
    .CLKS_PER_BIT(CLKS_BIT)
  ) dut_i (
    .clk     (clk),
    .reset   (reset),
    .tx_block(tx_block),
    .tx      (tx),
    .led     (led)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int unsigned value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = (value << 1) | lfsr_state[0];
    end
  endtask

  // Host hold-off phases of 1 to 64 cycles
  initial begin : holdoff_gen
    int unsigned phase_left;
    int unsigned r;
    tx_block   = 1'b0;
    lfsr_state = 32'h3bebd665;
    phase_left = 0;
    forever begin
      @(negedge clk);
      if (!random_holdoff) begin
        tx_block   = 1'b0;
        phase_left = 0;
      end else if (phase_left == 0) begin
        take_bits(1, r);
        tx_block = r[0];
        take_bits(6, r);
        phase_left = r;
      end else begin
        phase_left--;
      end
    end
  end

  // Expected text is eight decimal digits MSD first then CR LF
  function automatic msg_t expected_msg(input int unsigned count);
    msg_t        msg;
    int unsigned rest;
    rest = count;
    for (int p = 7; p >= 0; p--) begin
      msg[8*(NB-1-p) +: 8] = 8'h30 + 8'(rest % 10);
      rest = rest / 10;
    end
    msg[8*(NB-1-8) +: 8] = 8'h0D;
    msg[8*(NB-1-9) +: 8] = 8'h0A;
    return msg;
  endfunction

  function automatic logic [7:0] byte_at(input msg_t msg, input int p);
    return msg[8*(NB-1-p) +: 8];
  endfunction

  function automatic int unsigned decode_value(input msg_t msg);
    int unsigned value;
    value = 0;
    for (int p = 0; p < 8; p++) begin
      value = value * 10 + int'(byte_at(msg, p) - 8'h30);
    end
    return value;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR led got 0x%02h expected 0x%02h", got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout: %s", what);
  endtask

  // Digit range and the CR LF tail
  task automatic check_format(input msg_t msg);
    for (int p = 0; p < 8; p++) begin
      checks++;
      if (byte_at(msg, p) < 8'h30 || byte_at(msg, p) > 8'h39) begin
        errors++;
        $display("ERROR msg byte %0d 0x%02h is not a decimal digit", p, byte_at(msg, p));
      end
    end
    check_byte("msg cr", byte_at(msg, 8), 8'h0D);
    check_byte("msg lf", byte_at(msg, 9), 8'h0A);
  endtask

  // Serial decoder sampling tx near mid-bit on falling edges
  task automatic receive_byte(output logic [7:0] data, output bit ok);
    int waited;
    waited = 0;
    data   = '0;
    ok     = 1'b0;
    while (tx !== 1'b0 && waited < START_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0) begin
      report_timeout("no start bit arrived on tx");
      return;
    end
    repeat (CLKS_BIT / 2) @(negedge clk);
    if (tx !== 1'b0) begin
      errors++;
      $display("start bit did not hold low to mid-bit");
    end
    // LSB first
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_BIT) @(negedge clk);
      data[i] = tx;
    end
    repeat (CLKS_BIT) @(negedge clk);
    if (tx !== 1'b1) begin
      errors++;
      $display("stop bit missing, framing error on tx");
    end
    ok = 1'b1;
  endtask

  task automatic receive_message(output msg_t msg, output bit ok);
    logic [7:0] b;
    msg = '0;
    for (int p = 0; p < NB; p++) begin
      receive_byte(b, ok);
      if (!ok) begin
        return;
      end
      msg[8*(NB-1-p) +: 8] = b;
    end
  endtask

  task automatic wait_led(input logic [7:0] exp);
    int waited;
    waited = 0;
    while (led !== exp && waited < LED_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (led !== exp) begin
      $display("timeout: led did not reach the message count");
    end
    check_led(led, exp);
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d errors", name, errors - errors_at_start);
    end
  endtask

  // Line idle and led clear until the first start bit
  task automatic test_reset_idle();
    int         waited;
    logic [7:0] led_seen;
    errors_at_start = errors;
    waited   = 0;
    led_seen = 8'h00;
    while (tx === 1'b1 && waited < START_TIMEOUT) begin
      if (led !== 8'h00 && led_seen === 8'h00) begin
        led_seen = led;
      end
      @(negedge clk);
      waited++;
    end
    checks++;
    if (tx !== 1'b0) begin
      report_timeout("tx never left idle after reset");
    end else if (waited < REPORT_CYC) begin
      errors++;
      $display("tx dropped before the first report interval ended");
    end
    check_led(led_seen, 8'h00);
    end_test("reset_idle");
  endtask

  // Message k carries k report intervals
  task automatic test_in_order(input int k);
    msg_t msg;
    msg_t exp;
    bit   ok;
    errors_at_start = errors;
    receive_message(msg, ok);
    if (ok) begin
      exp = expected_msg(k * avionics_pkg::REPORT_MS);
      for (int p = 0; p < NB; p++) begin
        check_byte($sformatf("msg%0d byte %0d", k, p), byte_at(msg, p), byte_at(exp, p));
      end
      check_format(msg);
      msgs_seen++;
      last_value = decode_value(msg);
      wait_led(8'(msgs_seen));
    end
    end_test($sformatf("in_order_%0d", k));
  endtask

  // Under hold-off only whole intervals may be skipped
  task automatic test_holdoff(input int k);
    msg_t        msg;
    bit          ok;
    int unsigned value;
    errors_at_start = errors;
    receive_message(msg, ok);
    if (ok) begin
      check_format(msg);
      value = decode_value(msg);
      checks++;
      if (value <= last_value || (value - last_value) % avionics_pkg::REPORT_MS != 0) begin
        errors++;
        $display("ERROR ms_time got 0x%06h expected a step of 0x%0h above 0x%06h",
                 value, avionics_pkg::REPORT_MS, last_value);
      end
      msgs_seen++;
      last_value = value;
      wait_led(8'(msgs_seen));
    end
    end_test($sformatf("holdoff_%0d", k));
  endtask

  initial begin : run_tests
    reset          = 1'b1;
    random_holdoff = 1'b0;
    timed_out      = 1'b0;
    errors         = 0;
    checks         = 0;
    tests_ok       = 0;
    tests_bad      = 0;
    msgs_seen      = 0;
    last_value     = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_idle();
    for (int k = 1; k <= 4 && !timed_out; k++) begin
      test_in_order(k);
    end
    random_holdoff = 1'b1;
    for (int k = 1; k <= 4 && !timed_out; k++) begin
      test_holdoff(k);
    end
    random_holdoff = 1'b0;

    $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
rtl/avionics_pkg.sv
rtl/ms_clock.sv
rtl/bin_to_bcd.sv
rtl/uart_tx.sv
rtl/debug_ctrl.sv
rtl/avionics.sv
tests/avionics_chk.sv
tests/avionics_tb.sv
